//--- vlog.f
design/mem_cfg_pkg.sv
design/access_pkg.sv
design/access_channel.sv
design/byte_array.sv
design/read_assemble.sv
design/ram_top.sv
tb/ram_tb_assert.sv
tb/ram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the RAM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module ram_tb -f vlog.f -o ram_tb_sim

./obj_dir/ram_tb_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

//--- tb/ram_tb.sv
module ram_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_OPS   = 200;
    // Directed accesses plus the random mix, rounded up
    localparam int NUM_ACCESSES = 280;
    localparam int TIMEOUT      = (NUM_ACCESSES * 4 + 100) * CLK_PERIOD;
    localparam int IDLE_LIMIT   = 8;

    typedef logic [127:0] chk_t;

    logic                   clk;
    logic                   rst_n;
    logic                   rd_ins;
    logic                   wr_ins;
    mem_cfg_pkg::addr_t     addr_rd;
    logic [1:0]             data_type_rd;
    mem_cfg_pkg::addr_t     addr_wr;
    logic [1:0]             data_type_wr;
    mem_cfg_pkg::bus_t      data_bus_wr;
    mem_cfg_pkg::bus_t      data_bus_rd;
    logic                   rd_idle;
    logic                   wr_idle;
    mem_cfg_pkg::cfg_regs_t cfg_regs;

    logic [7:0]        model_mem [mem_cfg_pkg::ADDR_DEPTH];
    mem_cfg_pkg::bus_t exp_rd;
    int                errors;
    int                reads_issued;
    int                reads_checked;
    integer            seed;

    ram_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_ins       (rd_ins),
        .wr_ins       (wr_ins),
        .addr_rd      (addr_rd),
        .data_type_rd (data_type_rd),
        .addr_wr      (addr_wr),
        .data_type_wr (data_type_wr),
        .data_bus_wr  (data_bus_wr),
        .data_bus_rd  (data_bus_rd),
        .rd_idle      (rd_idle),
        .wr_idle      (wr_idle),
        .cfg_regs     (cfg_regs)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int size_bytes(input logic [1:0] size);
        case (size)
            access_pkg::SIZE_BYTE: return 1;
            access_pkg::SIZE_WORD: return 4;
            default:               return 8;
        endcase
    endfunction

    // Little-endian read with zero fill past the size and past the top
    function automatic mem_cfg_pkg::bus_t expected_read(input int addr, input logic [1:0] size);
        mem_cfg_pkg::bus_t result;
        result = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            if (addr + k < mem_cfg_pkg::ADDR_DEPTH) begin
                result[8*k +: 8] = model_mem[addr + k];
            end
        end
        return result;
    endfunction

    function automatic mem_cfg_pkg::cfg_regs_t model_cfg();
        mem_cfg_pkg::cfg_regs_t regs;
        for (int i = 0; i < mem_cfg_pkg::CFG_REG_COUNT; i++) begin
            regs[i] = model_mem[i];
        end
        return regs;
    endfunction

    function automatic mem_cfg_pkg::bus_t random_data();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    task automatic model_reset();
        for (int i = 0; i < mem_cfg_pkg::ADDR_DEPTH; i++) begin
            if (i < mem_cfg_pkg::CFG_REG_COUNT) begin
                model_mem[i] = mem_cfg_pkg::CFG_REG_DEFAULT[i];
            end else begin
                model_mem[i] = mem_cfg_pkg::DATA_DEFAULT;
            end
        end
    endtask

    task automatic model_write(input int addr, input logic [1:0] size,
                               input mem_cfg_pkg::bus_t data);
        for (int k = 0; k < size_bytes(size); k++) begin
            // Bytes past the top are dropped
            if (addr + k < mem_cfg_pkg::ADDR_DEPTH) begin
                model_mem[addr + k] = data[8*k +: 8];
            end
        end
    endtask

    task automatic check_value(input string name, input chk_t actual, input chk_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Called on the falling edge after the accepting edge
    task automatic finish_access(input string name, input logic is_wr);
        int low_cycles;
        low_cycles = 0;
        check_value(name, chk_t'(is_wr ? wr_idle : rd_idle), chk_t'(1'b0));
        while ((is_wr ? !wr_idle : !rd_idle) && low_cycles < IDLE_LIMIT) begin
            @(negedge clk);
            low_cycles++;
        end
        if (low_cycles >= IDLE_LIMIT) begin
            $display("ERROR at time %0t: %s stayed low, the channel never went idle",
                     $time, name);
            errors++;
        end else begin
            check_value({name, " low cycles"}, chk_t'(low_cycles), chk_t'(1));
        end
    endtask

    task automatic write_access(input int addr, input logic [1:0] size,
                                input mem_cfg_pkg::bus_t data);
        addr_wr      = mem_cfg_pkg::addr_t'(addr);
        data_type_wr = size;
        data_bus_wr  = data;
        wr_ins       = 1'b1;
        @(negedge clk);
        wr_ins = 1'b0;
        finish_access("wr_idle", 1'b1);
        model_write(addr, size, data);
        check_value("cfg_regs", chk_t'(cfg_regs), chk_t'(model_cfg()));
    endtask

    task automatic read_access(input int addr, input logic [1:0] size);
        exp_rd       = expected_read(addr, size);
        addr_rd      = mem_cfg_pkg::addr_t'(addr);
        data_type_rd = size;
        rd_ins       = 1'b1;
        reads_issued++;
        @(negedge clk);
        rd_ins = 1'b0;
        finish_access("rd_idle", 1'b0);
    endtask

    task automatic round_trip(input int addr, input logic [1:0] size);
        write_access(addr, size, random_data());
        read_access(addr, size);
    endtask

    task automatic random_access();
        int         addr;
        logic [1:0] size;
        addr = int'($unsigned($random(seed)) % mem_cfg_pkg::ADDR_DEPTH);
        size = 2'($unsigned($random(seed)) % 3);
        if ($random(seed) & 1) begin
            write_access(addr, size, random_data());
        end else begin
            read_access(addr, size);
        end
    endtask

    // Read data is valid while the read channel is busy
    always @(negedge clk) begin
        if (rst_n && !rd_idle) begin
            check_value("data_bus_rd", chk_t'(data_bus_rd), chk_t'(exp_rd));
            reads_checked++;
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed          = 81995;
        clk           = 1'b0;
        rst_n         = 1'b0;
        rd_ins        = 1'b0;
        wr_ins        = 1'b0;
        addr_rd       = '0;
        data_type_rd  = access_pkg::SIZE_BYTE;
        addr_wr       = '0;
        data_type_wr  = access_pkg::SIZE_BYTE;
        data_bus_wr   = '0;
        exp_rd        = '0;
        errors        = 0;
        reads_issued  = 0;
        reads_checked = 0;
        model_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset state
        check_value("cfg_regs", chk_t'(cfg_regs), chk_t'(mem_cfg_pkg::CFG_REG_DEFAULT));
        check_value("rd_idle", chk_t'(rd_idle), chk_t'(1'b1));
        check_value("wr_idle", chk_t'(wr_idle), chk_t'(1'b1));
        check_value("data_bus_rd", chk_t'(data_bus_rd),
                    chk_t'(expected_read(0, access_pkg::SIZE_BYTE)));
        for (int a = 0; a < mem_cfg_pkg::CFG_REG_COUNT; a++) begin
            read_access(a, access_pkg::SIZE_BYTE);
        end

        // Aligned and unaligned round trips
        round_trip(16, access_pkg::SIZE_BYTE);
        round_trip(37, access_pkg::SIZE_BYTE);
        round_trip(64, access_pkg::SIZE_WORD);
        round_trip(71, access_pkg::SIZE_WORD);
        round_trip(128, access_pkg::SIZE_DWORD);
        round_trip(203, access_pkg::SIZE_DWORD);

        // Narrow writes into a known doubleword, then narrow reads
        write_access(256, access_pkg::SIZE_DWORD, 64'h8877_6655_4433_2211);
        write_access(258, access_pkg::SIZE_BYTE, 64'hFFFF_FFFF_FFFF_FFA5);
        write_access(261, access_pkg::SIZE_WORD, 64'hFFFF_FFFF_CAFE_F00D);
        read_access(256, access_pkg::SIZE_DWORD);
        read_access(255, access_pkg::SIZE_DWORD);
        read_access(257, access_pkg::SIZE_BYTE);
        read_access(259, access_pkg::SIZE_WORD);
        read_access(264, access_pkg::SIZE_DWORD);

        // Accesses running off the top of memory
        for (int a = 505; a < mem_cfg_pkg::ADDR_DEPTH; a++) begin
            write_access(a, access_pkg::SIZE_DWORD, random_data());
            read_access(a, access_pkg::SIZE_DWORD);
            write_access(a, access_pkg::SIZE_WORD, random_data());
            read_access(a, access_pkg::SIZE_WORD);
        end
        read_access(504, access_pkg::SIZE_DWORD);
        read_access(0, access_pkg::SIZE_DWORD);

        // Config bytes written through the normal write channel
        write_access(3, access_pkg::SIZE_WORD, random_data());
        write_access(10, access_pkg::SIZE_BYTE, random_data());
        write_access(6, access_pkg::SIZE_DWORD, random_data());
        read_access(0, access_pkg::SIZE_DWORD);
        read_access(8, access_pkg::SIZE_DWORD);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            random_access();
        end

        if (reads_checked != reads_issued) begin
            $display("ERROR: %0d reads issued but %0d read results compared",
                     reads_issued, reads_checked);
            errors++;
        end
        errors += uut.assert_checks.failures;
        $display("Reads compared: %0d, assertion failures: %0d, errors: %0d",
                 reads_checked, uut.assert_checks.failures, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tb/ram_tb_assert.sv
module ram_tb_assert (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    rd_idle,
    input logic                    wr_idle,
    input mem_cfg_pkg::cfg_regs_t  cfg_regs,
    input mem_cfg_pkg::mem_bytes_t mem_bytes
);

    int failures = 0;

    // Both channels leave reset idle
    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (rd_idle && wr_idle))
        else begin
            $error("idle outputs not high in the first cycle after reset");
            failures++;
        end

    wr_idle_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                    $fell(wr_idle) |=> wr_idle)
        else begin
            $error("wr_idle low for more than one cycle");
            failures++;
        end

    rd_idle_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                    $fell(rd_idle) |=> rd_idle)
        else begin
            $error("rd_idle low for more than one cycle");
            failures++;
        end

    cfg_mirror: assert property (@(posedge clk) disable iff (!rst_n)
                                 cfg_regs == mem_bytes[mem_cfg_pkg::CFG_REG_COUNT-1:0])
        else begin
            $error("cfg_regs differs from storage bytes 0 to 10");
            failures++;
        end

endmodule

bind ram_top ram_tb_assert assert_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_idle   (rd_idle),
    .wr_idle   (wr_idle),
    .cfg_regs  (cfg_regs),
    .mem_bytes (mem_bytes)
);

//--- design/ram_top.sv
module ram_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      rd_ins,
    input  logic                                      wr_ins,
    input  mem_cfg_pkg::addr_t                        addr_rd,
    input  logic [$bits(access_pkg::access_size_t)-1:0] data_type_rd,
    input  mem_cfg_pkg::addr_t                        addr_wr,
    input  logic [$bits(access_pkg::access_size_t)-1:0] data_type_wr,
    input  mem_cfg_pkg::bus_t                         data_bus_wr,
    output mem_cfg_pkg::bus_t                         data_bus_rd,
    output logic                                      rd_idle,
    output logic                                      wr_idle,
    output mem_cfg_pkg::cfg_regs_t                    cfg_regs
);

    access_pkg::rd_req_t     rd_req;
    access_pkg::rd_req_t     rd_req_held;
    access_pkg::wr_req_t     wr_req;
    access_pkg::wr_req_t     wr_req_held;
    logic                    wr_commit;
    mem_cfg_pkg::mem_bytes_t mem_bytes;

    assign rd_req.addr = addr_rd;
    assign rd_req.size = access_pkg::access_size_t'(data_type_rd);

    assign wr_req.addr = addr_wr;
    assign wr_req.size = access_pkg::access_size_t'(data_type_wr);
    assign wr_req.data = data_bus_wr;

    // Read side needs no commit, the output follows storage directly
    access_channel #(.req_t(access_pkg::rd_req_t)) rd_channel (
        .clk      (clk),
        .rst_n    (rst_n),
        .strobe   (rd_ins),
        .req_in   (rd_req),
        .req_held (rd_req_held),
        .commit   (),
        .idle     (rd_idle)
    );

    access_channel #(.req_t(access_pkg::wr_req_t)) wr_channel (
        .clk      (clk),
        .rst_n    (rst_n),
        .strobe   (wr_ins),
        .req_in   (wr_req),
        .req_held (wr_req_held),
        .commit   (wr_commit),
        .idle     (wr_idle)
    );

    byte_array u_byte_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req_held),
        .wr_commit (wr_commit),
        .mem_bytes (mem_bytes),
        .cfg_regs  (cfg_regs)
    );

    read_assemble u_read_assemble (
        .rd_req    (rd_req_held),
        .mem_bytes (mem_bytes),
        .rd_data   (data_bus_rd)
    );

endmodule

//--- design/read_assemble.sv
module read_assemble (
    input  access_pkg::rd_req_t     rd_req,
    input  mem_cfg_pkg::mem_bytes_t mem_bytes,
    output mem_cfg_pkg::bus_t       rd_data
);

    mem_cfg_pkg::addr_t      rd_count;
    mem_cfg_pkg::bus_lanes_t rd_lanes;

    assign rd_count = mem_cfg_pkg::addr_t'(access_pkg::SIZE_BYTES[rd_req.size]);

    for (genvar k = 0; k < mem_cfg_pkg::BUS_BYTES; k++) begin : g_lane
        mem_cfg_pkg::addr_t lane_addr;
        logic               lane_valid;

        assign lane_addr = rd_req.addr + mem_cfg_pkg::addr_t'(k);

        // A wrapped lane address means the access ran off the top
        assign lane_valid = (mem_cfg_pkg::addr_t'(k) < rd_count)
                            && (lane_addr >= rd_req.addr);

        assign rd_lanes[k] = lane_valid ? mem_bytes[lane_addr] : '0;
    end

    // Unused lanes are already zero
    assign rd_data = rd_lanes;

endmodule

//--- design/byte_array.sv
module byte_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  access_pkg::wr_req_t     wr_req,
    input  logic                    wr_commit,
    output mem_cfg_pkg::mem_bytes_t mem_bytes,
    output mem_cfg_pkg::cfg_regs_t  cfg_regs
);

    mem_cfg_pkg::bus_lanes_t                  wr_lanes;
    mem_cfg_pkg::addr_t                       wr_count;
    logic [mem_cfg_pkg::ADDR_DEPTH-1:0]       byte_we;
    mem_cfg_pkg::mem_bytes_t                  byte_wd;

    assign wr_lanes = wr_req.data;
    assign wr_count = mem_cfg_pkg::addr_t'(access_pkg::SIZE_BYTES[wr_req.size]);

    // Per-byte enable and lane steering
    for (genvar i = 0; i < mem_cfg_pkg::ADDR_DEPTH; i++) begin : g_byte
        mem_cfg_pkg::addr_t byte_addr;
        mem_cfg_pkg::addr_t offset;

        assign byte_addr = mem_cfg_pkg::addr_t'(i);
        assign offset    = byte_addr - wr_req.addr;

        // Below the write address the offset wraps, so that case is masked
        assign byte_we[i] = wr_commit
                            && (byte_addr >= wr_req.addr)
                            && (offset < wr_count);

        assign byte_wd[i] = wr_lanes[offset[$clog2(mem_cfg_pkg::BUS_BYTES)-1:0]];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_bytes <= mem_cfg_pkg::MEM_DEFAULT;
        end else begin
            for (int i = 0; i < mem_cfg_pkg::ADDR_DEPTH; i++) begin
                if (byte_we[i]) begin
                    mem_bytes[i] <= byte_wd[i];
                end
            end
        end
    end

    // Config bytes are the bottom of storage
    assign cfg_regs = mem_bytes[mem_cfg_pkg::CFG_REG_COUNT-1:0];

endmodule

//--- design/access_channel.sv
module access_channel #(
    parameter type req_t = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic strobe,
    input  req_t req_in,
    output req_t req_held,
    output logic commit,
    output logic idle
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t state;
    logic   strobe_q;
    logic   accept;

    // Rising edge of the strobe, ignored while busy
    assign accept = strobe && !strobe_q && (state == ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= strobe;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_BUSY;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_held <= '0;
        end else if (accept) begin
            req_held <= req_in;
        end
    end

    // One busy cycle per access
    assign commit = (state == ST_BUSY);
    assign idle   = (state == ST_IDLE);

endmodule

//--- design/access_pkg.sv
package access_pkg;

    // Code 3 is not used
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } access_size_t;

    // Bytes moved per access size
    localparam logic [3:0] SIZE_BYTES [3] = '{4'd1, 4'd4, 4'd8};

    typedef struct packed {
        mem_cfg_pkg::addr_t addr;
        access_size_t       size;
    } rd_req_t;

    // Data is little-endian, lane 0 goes to addr
    typedef struct packed {
        mem_cfg_pkg::addr_t addr;
        access_size_t       size;
        mem_cfg_pkg::bus_t  data;
    } wr_req_t;

endpackage

//--- design/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // Memory geometry
    localparam int ADDR_DEPTH = 512;
    localparam int ADDR_WIDTH = $clog2(ADDR_DEPTH);
    localparam int BYTE_WIDTH = 8;
    localparam int BUS_BYTES  = 8;
    localparam int BUS_WIDTH  = BUS_BYTES * BYTE_WIDTH;

    // Peripheral configuration bytes at the bottom of memory
    localparam int CFG_REG_COUNT = 11;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [BUS_WIDTH-1:0]  bus_t;

    // Byte 0 sits in the lowest lane of each of these
    typedef logic [CFG_REG_COUNT-1:0][BYTE_WIDTH-1:0] cfg_regs_t;
    typedef logic [BUS_BYTES-1:0][BYTE_WIDTH-1:0]     bus_lanes_t;
    typedef logic [ADDR_DEPTH-1:0][BYTE_WIDTH-1:0]    mem_bytes_t;

    // Listed from address 10 down to address 0
    localparam cfg_regs_t CFG_REG_DEFAULT = {
        8'hF8, 8'h23, 8'h23, 8'h00, 8'h00, 8'h23,
        8'h23, 8'h00, 8'h00, 8'h00, 8'h00
    };

    localparam logic [BYTE_WIDTH-1:0] DATA_DEFAULT = '0;

    // Full reset image of the storage
    localparam mem_bytes_t MEM_DEFAULT = {
        {(ADDR_DEPTH - CFG_REG_COUNT){DATA_DEFAULT}},
        CFG_REG_DEFAULT
    };

endpackage
